// ==== compile.f ====
+incdir+hw
hw/axi_ar_pkg.sv
hw/tlp_pkg.sv
hw/ar_unpack.sv
hw/rdreq_sizer.sv
hw/rdreq_hdr_out.sv
hw/rd_atop.sv
test/rd_atop_checker.sv
test/tb_rd_atop.sv

// ==== Makefile ====
# Verilator build and run of the rd_atop testbench

VERILATOR ?= verilator
TOP       ?= tb_rd_atop
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) hw/rd_atop_defs.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_rd_atop.sv ====
`include "rd_atop_defs.svh"

module tb_rd_atop;
   timeunit 1ns;
   timeprecision 1ps;

   import tlp_pkg::*;

   // Words per test
   localparam int N_MEM = 96;
   localparam int N_IO  = 8;
   localparam int N_MIX = 32;
   localparam int N_TAG = 32;
   localparam int N_BP  = 24;
   localparam int N_EN  = 6;
   localparam int CYC_LIMIT = 4 * (N_MEM + N_IO + N_MIX + N_TAG + N_BP + N_EN) + 200;

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic                  rd_atop_en;
   logic [`AR_WORD_W-1:0] ar_fifo_data;
   logic                  ar_fifo_empty;
   logic                  ar_fifo_rd;
   logic [`REQ_ID_W-1:0]  requester_id;
   logic                  config_ecrc;
   tlp_hdr_t              hdr;
   logic                  hdr_valid;
   logic                  hdr_grant;
   logic                  rec_wr_en;
   logic [7:0]            rec_wr_addr;
   logic [`AR_ID_W-1:0]   rec_wr_id;
   int                    errors;
   int                    checked;
   int                    dropped;
   int                    pending;

   // FIFO model, head word is presented to the DUT
   logic [`AR_WORD_W-1:0] fifo_q[$];
   logic [31:0]           lfsr = 32'h06074ea7;
   // Values applied at the next falling edge
   logic                  en_q = 1'b0;
   logic                  ecrc_q = 1'b0;
   logic [`REQ_ID_W-1:0]  reqid_q = 16'h0100;
   int gap_bits = 0;
   int wait_bits = 0;
   int grant_wait = 0;
   int cycles = 0;
   int tb_errors = 0;
   int err0 = 0;
   int chk0 = 0;

   always #2 clk = ~clk;

   rd_atop uut (
      .clk           (clk),
      .rst_n         (rst_n),
      .rd_atop_en    (rd_atop_en),
      .ar_fifo_data  (ar_fifo_data),
      .ar_fifo_empty (ar_fifo_empty),
      .ar_fifo_rd    (ar_fifo_rd),
      .requester_id  (requester_id),
      .config_ecrc   (config_ecrc),
      .hdr           (hdr),
      .hdr_valid     (hdr_valid),
      .hdr_grant     (hdr_grant),
      .rec_wr_en     (rec_wr_en),
      .rec_wr_addr   (rec_wr_addr),
      .rec_wr_id     (rec_wr_id)
   );

   rd_atop_checker chk (.*);

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[62:0], fb};
      end
      return v;
   endfunction

   function automatic void push_word(input logic [2:0] user, input logic [2:0] size,
                                     input logic [7:0] len, input logic [1:0] lo,
                                     input logic [3:0] id);
      logic [`AR_WORD_W-1:0] w;
      w = '0;
      w[`AR_USER_LSB +: `AR_USER_W]   = user;
      w[`AR_BURST_LSB +: `AR_BURST_W] = 2'(rand_bits(2));
      w[`AR_SIZE_LSB +: `AR_SIZE_W]   = size;
      w[`AR_LEN_LSB +: `AR_LEN_W]     = len;
      w[`AR_ADDR_LSB +: `AR_ADDR_W]   = {62'(rand_bits(62)), lo};
      w[`AR_ID_LSB +: `AR_ID_W]       = id;
      fifo_q.push_back(w);
   endfunction

   // Waits until everything read has been granted, then reports the test
   task automatic end_test(input string name);
      do @(negedge clk); while (fifo_q.size() != 0 || pending != 0 || hdr_valid);
      $display("%-10s %s headers=%0d errors=%0d", name,
               (errors + tb_errors == err0) ? "ok  " : "fail", checked - chk0,
               errors + tb_errors - err0);
      err0 = errors + tb_errors;
      chk0 = checked;
      @(posedge clk);
   endtask

   // Inputs move on the falling edge, grant after a random wait
   always @(negedge clk) begin
      rd_atop_en    = en_q;
      config_ecrc   = ecrc_q;
      requester_id  = reqid_q;
      ar_fifo_empty = (fifo_q.size() == 0) || (gap_bits != 0 && rand_bits(gap_bits) == 0);
      ar_fifo_data  = (fifo_q.size() != 0) ? fifo_q[0] : '0;
      hdr_grant     = 1'b0;
      if (hdr_valid === 1'b1) begin
         if (grant_wait == 0) begin
            hdr_grant  = 1'b1;
            grant_wait = int'(rand_bits(wait_bits));
         end else begin
            grant_wait--;
         end
      end
   end

   // FIFO pops and the run limit
   always @(posedge clk) begin
      cycles++;
      if (ar_fifo_rd === 1'b1 && fifo_q.size() != 0)
         void'(fifo_q.pop_front());
      if (cycles >= CYC_LIMIT) begin
         $display("Run stopped: requests still pending after %0d cycles", CYC_LIMIT);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   initial begin
      rst_n = 1'b0;
      rd_atop_en = 1'b0;
      ar_fifo_data = '0;
      ar_fifo_empty = 1'b1;
      requester_id = '0;
      config_ecrc = 1'b0;
      hdr_grant = 1'b0;
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      if (ar_fifo_rd !== 1'b0 || hdr_valid !== 1'b0 || rec_wr_en !== 1'b0) begin
         tb_errors++;
         $display("Control outputs were not all low after reset");
      end
      @(posedge clk);
      en_q = 1'b1;
      wait_bits = 1;
      // 32 and 64 bit memory reads, every size, short and random lengths
      for (int a = 0; a < 2; a++)
         for (int s = 0; s < 8; s++)
            for (int l = 0; l < 6; l++)
               push_word({a[0], 2'b01}, 3'(s), (l < 5) ? 8'(l) : 8'(rand_bits(8)),
                         2'(rand_bits(2)), 4'(rand_bits(4)));
      end_test("mem_rd");
      for (int k = 0; k < N_IO; k++)
         push_word(3'b010, 3'(rand_bits(3)), 8'(rand_bits(8)), 2'(k), 4'(rand_bits(4)));
      end_test("io_rd");
      // Any user encoding, with empty gaps
      gap_bits = 2;
      for (int k = 0; k < N_MIX; k++)
         push_word(3'(rand_bits(3)), 3'(rand_bits(3)), 8'(rand_bits(8)), 2'(rand_bits(2)),
                   4'(rand_bits(4)));
      end_test("mixed");
      // ECRC and requester ID change only while idle
      for (int r = 0; r < 4; r++) begin
         ecrc_q  = r[0];
         reqid_q = 16'(rand_bits(16));
         for (int k = 0; k < N_TAG / 4; k++)
            push_word({1'(rand_bits(1)), 2'b01}, 3'(rand_bits(3)), 8'(rand_bits(8)),
                      2'(rand_bits(2)), 4'(r * 8 + k));
         end_test("tag_td");
      end
      // Long grant delays fill the pipeline
      wait_bits = 4;
      for (int k = 0; k < N_BP; k++)
         push_word(3'(rand_bits(3)), 3'(rand_bits(3)), 8'(rand_bits(8)), 2'(rand_bits(2)),
                   4'(rand_bits(4)));
      end_test("backpress");
      wait_bits = 1;
      en_q = 1'b0;
      for (int k = 0; k < N_EN; k++)
         push_word(3'b001, 3'(rand_bits(3)), 8'(rand_bits(8)), 2'b00, 4'(k));
      repeat (40) @(posedge clk);
      if (fifo_q.size() != N_EN) begin
         tb_errors++;
         $display("FIFO advanced while rd_atop_en was low");
      end
      en_q = 1'b1;
      end_test("enable");
      $display("Totals: headers=%0d dropped=%0d errors=%0d", checked, dropped,
               errors + tb_errors);
      if (errors + tb_errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// ==== test/rd_atop_checker.sv ====
`include "rd_atop_defs.svh"

module rd_atop_checker (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  rd_atop_en,
   input  logic [`AR_WORD_W-1:0] ar_fifo_data,
   input  logic                  ar_fifo_empty,
   input  logic                  ar_fifo_rd,
   input  logic [`REQ_ID_W-1:0]  requester_id,
   input  logic                  config_ecrc,
   input  tlp_pkg::tlp_hdr_t     hdr,
   input  logic                  hdr_valid,
   input  logic                  hdr_grant,
   input  logic                  rec_wr_en,
   input  logic [7:0]            rec_wr_addr,
   input  logic [`AR_ID_W-1:0]   rec_wr_id,
   output int                    errors,
   output int                    checked,
   output int                    dropped,
   output int                    pending
);
   timeunit 1ns;
   timeprecision 1ps;

   import tlp_pkg::*;

   // Expected headers in read order
   tlp_hdr_t exp_q[$];
   tlp_hdr_t held;
   logic     waiting;

   // Expected header for one FIFO word, supported is low for words that are dropped
   function automatic tlp_hdr_t expect_hdr(
      input  logic [`AR_WORD_W-1:0] word,
      input  logic [`REQ_ID_W-1:0]  req_id,
      input  logic                  ecrc,
      output logic                  supported
   );
      logic [2:0]  user;
      logic [63:0] addr;
      logic        is_mem;
      logic        is_io;
      int unsigned bytes;
      int unsigned dws;
      tlp_hdr_t    h;
      user   = word[`AR_USER_LSB +: `AR_USER_W];
      addr   = word[`AR_ADDR_LSB +: `AR_ADDR_W];
      is_mem = (user[1:0] == 2'b01);
      // No 64-bit IO space
      is_io  = (user[1:0] == 2'b10) && !user[2];
      supported = is_mem || is_io;
      h = '0;
      h.fmt     = (is_mem && user[2]) ? FMT_4DW_NODATA : FMT_3DW_NODATA;
      h.typ     = is_io ? TYPE_IO : TYPE_MEM;
      h.attr_hi = 1'b1;
      h.th      = 1'b1;
      h.attr    = 2'b10;
      h.td      = ecrc;
      h.requester_id = req_id;
      h.tag     = 8'h80 | 8'(word[`AR_ID_LSB +: `AR_ID_W]);
      if (is_io) begin
         h.length   = 10'd1;
         h.first_be = 4'(4'b1111 << addr[1:0]);
         h.last_be  = 4'b0000;
      end else begin
         // Beats times beat bytes, then whole DWs
         bytes = (int'(word[`AR_LEN_LSB +: `AR_LEN_W]) + 1) << word[`AR_SIZE_LSB +: `AR_SIZE_W];
         dws   = (bytes + 3) / 4;
         if (dws == 0)
            dws = 1;
         h.length   = 10'(dws % 1024);
         h.first_be = 4'b1111;
         h.last_be  = (h.length == 10'd1) ? 4'b0000 : 4'b1111;
      end
      if (is_mem && user[2]) begin
         h.higher_addr = addr[63:32];
         h.lower_addr  = addr[31:2];
      end else begin
         h.higher_addr = {addr[31:2], 2'b00};
      end
      return h;
   endfunction

   always @(posedge clk) begin
      tlp_hdr_t want;
      logic     ok;
      if (!rst_n) begin
         exp_q.delete();
         errors  = 0;
         checked = 0;
         dropped = 0;
         waiting = 1'b0;
      end else begin
         // Offered header holds until the grant edge
         if (waiting && (hdr_valid !== 1'b1 || hdr !== held)) begin
            errors++;
            $display("ERROR @%0t: header changed or dropped before grant", $time);
         end
         waiting = (hdr_valid === 1'b1) && !hdr_grant;
         held    = hdr;
         if (ar_fifo_rd) begin
            if (ar_fifo_empty || !rd_atop_en) begin
               errors++;
               $display("ERROR @%0t: FIFO read with empty=%b en=%b", $time, ar_fifo_empty,
                        rd_atop_en);
            end
            want = expect_hdr(ar_fifo_data, requester_id, config_ecrc, ok);
            if (ok)
               exp_q.push_back(want);
            else
               dropped++;
         end
         if (rec_wr_en) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("ERROR @%0t: recorder write with no request outstanding", $time);
            end else begin
               want = exp_q.pop_front();
               checked++;
               if (hdr !== want || rec_wr_addr !== want.tag ||
                   rec_wr_id !== want.tag[`AR_ID_W-1:0]) begin
                  errors++;
                  $display("ERROR @%0t: hdr %h rec %h/%h, expected hdr %h tag %h", $time,
                           hdr, rec_wr_addr, rec_wr_id, want, want.tag);
               end
            end
         end
      end
      pending = exp_q.size();
   end

endmodule

// ==== hw/rd_atop.sv ====
`include "rd_atop_defs.svh"

module rd_atop (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     rd_atop_en,
   input  logic [`AR_WORD_W-1:0]    ar_fifo_data,
   input  logic                     ar_fifo_empty,
   output logic                     ar_fifo_rd,
   input  logic [`REQ_ID_W-1:0]     requester_id,
   input  logic                     config_ecrc,
   output tlp_pkg::tlp_hdr_t        hdr,
   output logic                     hdr_valid,
   input  logic                     hdr_grant,
   output logic                     rec_wr_en,
   output logic [7:0]               rec_wr_addr,
   output axi_ar_pkg::ar_id_t       rec_wr_id
);

   import axi_ar_pkg::*;

   // Unpacker to sizer
   logic                  u_valid;
   req_kind_e             u_kind;
   ar_len_t               u_len;
   ar_size_t              u_size;
   ar_addr_t              u_addr;
   ar_id_t                u_id;
   logic                  sizer_stall;

   // Sizer to header stage
   logic                  s_valid;
   req_kind_e             s_kind;
   ar_addr_t              s_addr;
   ar_id_t                s_id;
   logic [`TLP_LEN_W-1:0] s_length;
   logic [3:0]            s_first_be;
   logic [3:0]            s_last_be;
   logic                  out_stall;

   ar_unpack u_unpack (
      .clk           (clk),
      .rst_n         (rst_n),
      .rd_atop_en    (rd_atop_en),
      .ar_fifo_data  (ar_fifo_data),
      .ar_fifo_empty (ar_fifo_empty),
      .stall         (sizer_stall),
      .ar_fifo_rd    (ar_fifo_rd),
      .u_valid       (u_valid),
      .u_kind        (u_kind),
      .u_len         (u_len),
      .u_size        (u_size),
      .u_addr        (u_addr),
      .u_id          (u_id)
   );

   rdreq_sizer u_sizer (
      .clk         (clk),
      .rst_n       (rst_n),
      .u_valid     (u_valid),
      .u_kind      (u_kind),
      .u_len       (u_len),
      .u_size      (u_size),
      .u_addr      (u_addr),
      .u_id        (u_id),
      .stall       (out_stall),
      .s_valid     (s_valid),
      .s_kind      (s_kind),
      .s_addr      (s_addr),
      .s_id        (s_id),
      .s_length    (s_length),
      .s_first_be  (s_first_be),
      .s_last_be   (s_last_be),
      .sizer_stall (sizer_stall)
   );

   rdreq_hdr_out u_hdr_out (
      .clk          (clk),
      .rst_n        (rst_n),
      .s_valid      (s_valid),
      .s_kind       (s_kind),
      .s_addr       (s_addr),
      .s_id         (s_id),
      .s_length     (s_length),
      .s_first_be   (s_first_be),
      .s_last_be    (s_last_be),
      .requester_id (requester_id),
      .config_ecrc  (config_ecrc),
      .hdr_grant    (hdr_grant),
      .hdr          (hdr),
      .hdr_valid    (hdr_valid),
      .out_stall    (out_stall),
      .rec_wr_en    (rec_wr_en),
      .rec_wr_addr  (rec_wr_addr),
      .rec_wr_id    (rec_wr_id)
   );

endmodule

// ==== hw/rdreq_hdr_out.sv ====
`include "rd_atop_defs.svh"

module rdreq_hdr_out (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     s_valid,
   input  axi_ar_pkg::req_kind_e    s_kind,
   input  axi_ar_pkg::ar_addr_t     s_addr,
   input  axi_ar_pkg::ar_id_t       s_id,
   input  logic [`TLP_LEN_W-1:0]    s_length,
   input  logic [3:0]               s_first_be,
   input  logic [3:0]               s_last_be,
   input  logic [`REQ_ID_W-1:0]     requester_id,
   input  logic                     config_ecrc,
   input  logic                     hdr_grant,
   output tlp_pkg::tlp_hdr_t        hdr,
   output logic                     hdr_valid,
   output logic                     out_stall,
   output logic                     rec_wr_en,
   output logic [7:0]               rec_wr_addr,
   output axi_ar_pkg::ar_id_t       rec_wr_id
);

   import axi_ar_pkg::*;
   import tlp_pkg::*;

   // Zero bits between the read marker and the ID in the tag
   localparam int TAG_PAD = 7 - `AR_ID_W;

   tlp_hdr_t hdr_d;
   logic     load;

   always_comb begin
      hdr_d = '0;
      // Format and type from the kind
      hdr_d.fmt = (s_kind == REQ_MEMRD64) ? FMT_4DW_NODATA : FMT_3DW_NODATA;
      hdr_d.typ = (s_kind == REQ_IORD) ? TYPE_IO : TYPE_MEM;
      // Fixed fields
      hdr_d.tc      = TLP_TC;
      hdr_d.attr_hi = TLP_ATTR_HI;
      hdr_d.ln      = TLP_LN;
      hdr_d.th      = TLP_TH;
      hdr_d.ep      = TLP_EP;
      hdr_d.attr    = TLP_ATTR;
      hdr_d.at      = TLP_AT;
      // ECRC only when configuration asks for it
      hdr_d.td = config_ecrc;
      hdr_d.length = s_length;
      hdr_d.requester_id = requester_id;
      hdr_d.tag = {TLP_RD_TAG_MSB, {TAG_PAD{1'b0}}, s_id};
      hdr_d.last_be  = s_last_be;
      hdr_d.first_be = s_first_be;
      if (s_kind == REQ_MEMRD64) begin
         hdr_d.higher_addr = s_addr[63:32];
         hdr_d.lower_addr  = s_addr[31:2];
      end else begin
         // 3DW form, DW3 unused
         hdr_d.higher_addr = {s_addr[31:2], 2'b00};
         hdr_d.lower_addr  = '0;
      end
      hdr_d.ph = 2'b00;
   end

   // Waiting on the arbiter
   assign out_stall = hdr_valid && !hdr_grant;
   assign load      = !hdr_valid || hdr_grant;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hdr_valid <= 1'b0;
      end else if (load) begin
         hdr_valid <= s_valid;
      end
   end

   // Header is held until granted
   always_ff @(posedge clk) begin
      if (load && s_valid) begin
         hdr <= hdr_d;
      end
   end

   // Recorder write lands with the grant
   assign rec_wr_en   = hdr_grant && hdr_valid;
   assign rec_wr_addr = hdr.tag;
   assign rec_wr_id   = hdr.tag[`AR_ID_W-1:0];

   // Offered header does not move until the arbiter takes it
   a_hdr_hold: assert property (
      @(posedge clk) disable iff (!rst_n)
      hdr_valid && !hdr_grant |=> hdr_valid && $stable(hdr)
   );

endmodule

// ==== hw/rdreq_sizer.sv ====
`include "rd_atop_defs.svh"

module rdreq_sizer (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     u_valid,
   input  axi_ar_pkg::req_kind_e    u_kind,
   input  axi_ar_pkg::ar_len_t      u_len,
   input  axi_ar_pkg::ar_size_t     u_size,
   input  axi_ar_pkg::ar_addr_t     u_addr,
   input  axi_ar_pkg::ar_id_t       u_id,
   input  logic                     stall,
   output logic                     s_valid,
   output axi_ar_pkg::req_kind_e    s_kind,
   output axi_ar_pkg::ar_addr_t     s_addr,
   output axi_ar_pkg::ar_id_t       s_id,
   output logic [`TLP_LEN_W-1:0]    s_length,
   output logic [3:0]               s_first_be,
   output logic [3:0]               s_last_be,
   output logic                     sizer_stall
);

   import axi_ar_pkg::*;

   // Wide enough for 256 beats of 128 bytes
   localparam int BYTE_W = `AR_LEN_W + (1 << `AR_SIZE_W);

   logic [BYTE_W-1:0]     byte_cnt;
   logic [BYTE_W-1:0]     byte_rnd;
   logic [`TLP_LEN_W-1:0] length_d;
   logic [3:0]            first_be_d;
   logic [3:0]            last_be_d;
   logic                  load;

   // Bytes in the burst, then DWs rounded up
   assign byte_cnt = (BYTE_W'(u_len) + BYTE_W'(1)) << u_size;
   assign byte_rnd = byte_cnt + BYTE_W'(3);

   always_comb begin
      if (u_kind == REQ_IORD) begin
         // Single DW with enables from the byte offset
         length_d  = `TLP_LEN_W'(1);
         last_be_d = 4'b0000;
         case (u_addr[1:0])
            2'b00:   first_be_d = 4'b1111;
            2'b01:   first_be_d = 4'b1110;
            2'b10:   first_be_d = 4'b1100;
            default: first_be_d = 4'b1000;
         endcase
      end else begin
         // A nonzero byte count gives at least one DW
         // 1024 DW wraps to 0
         length_d   = byte_rnd[2 +: `TLP_LEN_W];
         first_be_d = 4'b1111;
         last_be_d  = (length_d == `TLP_LEN_W'(1)) ? 4'b0000 : 4'b1111;
      end
   end

   // Full and the output stage is not taking us
   assign sizer_stall = s_valid && stall;
   assign load        = !s_valid || !stall;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s_valid <= 1'b0;
         s_kind  <= REQ_NONE;
      end else if (load) begin
         s_valid <= u_valid;
         s_kind  <= u_kind;
      end
   end

   // Payload follows the valid bit
   always_ff @(posedge clk) begin
      if (load && u_valid) begin
         s_addr     <= u_addr;
         s_id       <= u_id;
         s_length   <= length_d;
         s_first_be <= first_be_d;
         s_last_be  <= last_be_d;
      end
   end

endmodule

// ==== hw/ar_unpack.sv ====
`include "rd_atop_defs.svh"

module ar_unpack (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     rd_atop_en,
   input  logic [`AR_WORD_W-1:0]    ar_fifo_data,
   input  logic                     ar_fifo_empty,
   input  logic                     stall,
   output logic                     ar_fifo_rd,
   output logic                     u_valid,
   output axi_ar_pkg::req_kind_e    u_kind,
   output axi_ar_pkg::ar_len_t      u_len,
   output axi_ar_pkg::ar_size_t     u_size,
   output axi_ar_pkg::ar_addr_t     u_addr,
   output axi_ar_pkg::ar_id_t       u_id
);

   import axi_ar_pkg::*;

   ar_user_t  user;
   req_kind_e kind;

   // User bits sit at the bottom of the FIFO word
   assign user = ar_fifo_data[`AR_USER_LSB +: `AR_USER_W];

   // Classify the head word
   always_comb begin
      case (user[1:0])
         USER_TYPE_MEMRD: begin
            kind = user[USER_ADDR64_BIT] ? REQ_MEMRD64 : REQ_MEMRD32;
         end
         USER_TYPE_IORD: begin
            // IO space has no 64-bit form
            kind = user[USER_ADDR64_BIT] ? REQ_NONE : REQ_IORD;
         end
         default: begin
            kind = REQ_NONE;
         end
      endcase
   end

   // Pop when enabled, data present and our register is free or moving on
   assign ar_fifo_rd = rd_atop_en && !ar_fifo_empty && (!u_valid || !stall);

   // Control register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         u_valid <= 1'b0;
         u_kind  <= REQ_NONE;
      end else if (ar_fifo_rd) begin
         // Unsupported words are swallowed here
         u_valid <= (kind != REQ_NONE);
         u_kind  <= kind;
      end else if (!stall) begin
         u_valid <= 1'b0;
      end
   end

   // Field slices, captured on every pop
   always_ff @(posedge clk) begin
      if (ar_fifo_rd) begin
         u_len  <= ar_fifo_data[`AR_LEN_LSB  +: `AR_LEN_W];
         u_size <= ar_fifo_data[`AR_SIZE_LSB +: `AR_SIZE_W];
         u_addr <= ar_fifo_data[`AR_ADDR_LSB +: `AR_ADDR_W];
         u_id   <= ar_fifo_data[`AR_ID_LSB   +: `AR_ID_W];
      end
   end

   // FIFO is never popped while empty
   a_no_rd_on_empty: assert property (
      @(posedge clk) disable iff (!rst_n)
      ar_fifo_rd |-> !ar_fifo_empty
   );

endmodule

// ==== hw/tlp_pkg.sv ====
`include "rd_atop_defs.svh"

package tlp_pkg;

   // Fmt field, read requests carry no data
   typedef enum logic [2:0] {
      FMT_3DW_NODATA = 3'b000,
      FMT_4DW_NODATA = 3'b001
   } tlp_fmt_e;

   // Type field
   typedef enum logic [4:0] {
      TYPE_MEM = 5'b00000,
      TYPE_IO  = 5'b00010
   } tlp_type_e;

   // Four DW request header, DW0 in the top bits
   typedef struct packed {
      // DW0
      tlp_fmt_e               fmt;
      tlp_type_e              typ;
      logic                   t9;
      logic [2:0]             tc;
      logic                   t8;
      logic                   attr_hi;
      logic                   ln;
      logic                   th;
      logic                   td;
      logic                   ep;
      logic [1:0]             attr;
      logic [1:0]             at;
      logic [`TLP_LEN_W-1:0]  length;
      // DW1
      logic [`REQ_ID_W-1:0]   requester_id;
      logic [7:0]             tag;
      logic [3:0]             last_be;
      logic [3:0]             first_be;
      // DW2
      logic [31:0]            higher_addr;
      // DW3
      logic [29:0]            lower_addr;
      logic [1:0]             ph;
   } tlp_hdr_t;

   // Fixed header fields for read requests
   localparam logic [2:0] TLP_TC      = 3'b000;
   localparam logic [1:0] TLP_ATTR    = 2'b10;
   localparam logic       TLP_ATTR_HI = 1'b1;
   localparam logic       TLP_TH      = 1'b1;
   localparam logic       TLP_EP      = 1'b0;
   localparam logic       TLP_LN      = 1'b0;
   localparam logic [1:0] TLP_AT      = 2'b00;

   // Read tags carry a 1 in the MSB
   localparam logic TLP_RD_TAG_MSB = 1'b1;

endpackage

// ==== hw/axi_ar_pkg.sv ====
`include "rd_atop_defs.svh"

package axi_ar_pkg;

   // Request kind decoded from the AR user bits
   typedef enum logic [1:0] {
      REQ_NONE    = 2'd0,
      REQ_MEMRD32 = 2'd1,
      REQ_MEMRD64 = 2'd2,
      REQ_IORD    = 2'd3
   } req_kind_e;

   // Unpacked AR fields
   typedef logic [`AR_ID_W-1:0]   ar_id_t;
   typedef logic [`AR_ADDR_W-1:0] ar_addr_t;
   typedef logic [`AR_LEN_W-1:0]  ar_len_t;
   typedef logic [`AR_SIZE_W-1:0] ar_size_t;
   typedef logic [`AR_USER_W-1:0] ar_user_t;

   // Request type encoding in user[1:0]
   localparam logic [1:0] USER_TYPE_MEMRD = 2'b01;
   localparam logic [1:0] USER_TYPE_IORD  = 2'b10;

   // Set in user bits for a 64-bit address
   localparam int USER_ADDR64_BIT = 2;

endpackage

// ==== hw/rd_atop_defs.svh ====
`ifndef RD_ATOP_DEFS_SVH
`define RD_ATOP_DEFS_SVH

// AR channel field widths
`define AR_ID_W     4
`define AR_ADDR_W   64
`define AR_LEN_W    8
`define AR_SIZE_W   3
`define AR_BURST_W  2
`define AR_USER_W   3

// PCIe side widths
`define REQ_ID_W    16
`define TLP_LEN_W   10

// Whole AR FIFO word
`define AR_WORD_W   (`AR_ID_W + `AR_ADDR_W + `AR_LEN_W + `AR_SIZE_W + `AR_BURST_W + `AR_USER_W)

// FIFO word layout, LSB first: user, burst, size, len, addr, id
`define AR_USER_LSB   0
`define AR_BURST_LSB  (`AR_USER_LSB + `AR_USER_W)
`define AR_SIZE_LSB   (`AR_BURST_LSB + `AR_BURST_W)
`define AR_LEN_LSB    (`AR_SIZE_LSB + `AR_SIZE_W)
`define AR_ADDR_LSB   (`AR_LEN_LSB + `AR_LEN_W)
`define AR_ID_LSB     (`AR_ADDR_LSB + `AR_ADDR_W)

`endif
